/* logic/spi_xip_pkg.sv */
package spi_xip_pkg;

  // XIP window, every read here becomes a flash read
  localparam logic [31:0] flash_base = 32'h3000_0000;
  localparam logic [31:0] flash_last = 32'h3fff_ffff;

  // Direct SPI register window
  localparam logic [31:0] regs_base = 32'h1000_1000;
  localparam logic [31:0] regs_last = 32'h1000_1fff;

  // Slave select lines on the pads
  localparam int ss_count = 8;

  // Control register field positions
  // Char length in 6:0, zero means 64 bits
  localparam int ctrl_char_len_lsb = 0;
  localparam int ctrl_go_bit       = 8;
  localparam int ctrl_ie_bit       = 12;

  // Serial flash read command
  localparam logic [7:0] flash_read_op = 8'h03;

  // SCK divider used by the XIP sequencer
  localparam logic [15:0] xip_divider = 16'd1;

  // Register offsets on the internal bus
  typedef enum logic [4:0] {
    rx0_tx0 = 5'h00,
    rx1_tx1 = 5'h04,
    ctrl    = 5'h10,
    divider = 5'h14,
    ss      = 5'h18
  } reg_sel_t;

  // XIP sequencer states
  typedef enum logic [3:0] {
    idle,
    send_cmd,
    set_divider,
    set_ss,
    go_busy,
    wait_complete,
    read_data,
    release_ss,
    respond
  } xip_state_t;

endpackage

/* logic/spi_regs.sv */
`timescale 1ns/1ns

module spi_regs (
  input  logic                            clock,
  input  logic                            reset,
  input  spi_xip_pkg::reg_sel_t           adr_i,
  input  logic [31:0]                     wdat_i,
  input  logic [3:0]                      sel_i,
  input  logic                            we_i,
  input  logic                            stb_i,
  output logic                            ack_o,
  output logic [31:0]                     rdat_o,
  output logic                            start_o,
  output logic [63:0]                     tx_word_o,
  output logic [6:0]                      char_len_o,
  output logic [15:0]                     divider_o,
  input  logic                            busy_i,
  input  logic                            done_i,
  input  logic [63:0]                     rx_word_i,
  output logic [spi_xip_pkg::ss_count-1:0] ss_n_o,
  output logic                            irq_o
);
  import spi_xip_pkg::*;

  // Control and config state
  logic                ack_q;
  logic                served_q;
  logic                start_q;
  logic [6:0]          char_len_q;
  logic                ie_q;
  logic [15:0]         divider_q;
  logic [ss_count-1:0] ss_q;
  logic                irq_q;
  // Payload
  logic [63:0]         tx_q;
  logic [63:0]         rx_q;
  logic [31:0]         rdat_q;
  // Decode helpers
  logic                req;
  logic                wr;
  logic [31:0]         ctrl_img;
  logic [31:0]         rd_w;
  logic [31:0]         old_w;
  logic [31:0]         new_w;

  // Merge write data into old word per byte lane
  function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  lanes);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // New request, once per strobe
  assign req = stb_i && !ack_q && !served_q;
  assign wr  = req && we_i;

  // Control image without the go bit
  always_comb begin
    ctrl_img = '0;
    ctrl_img[ctrl_char_len_lsb +: 7] = char_len_q;
    ctrl_img[ctrl_ie_bit] = ie_q;
  end

  // Read data, go reads back as busy
  always_comb begin
    case (adr_i)
      rx0_tx0: rd_w = rx_q[31:0];
      rx1_tx1: rd_w = rx_q[63:32];
      ctrl:    rd_w = ctrl_img | (32'(busy_i | start_q) << ctrl_go_bit);
      divider: rd_w = {16'b0, divider_q};
      ss:      rd_w = 32'(ss_q);
      default: rd_w = '0;
    endcase
  end

  // Current value of the write target
  always_comb begin
    case (adr_i)
      rx0_tx0: old_w = tx_q[31:0];
      rx1_tx1: old_w = tx_q[63:32];
      ctrl:    old_w = ctrl_img;
      divider: old_w = {16'b0, divider_q};
      ss:      old_w = 32'(ss_q);
      default: old_w = '0;
    endcase
  end

  assign new_w = byte_merge(old_w, wdat_i, sel_i);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q      <= 1'b0;
      served_q   <= 1'b0;
      start_q    <= 1'b0;
      char_len_q <= 7'd0;
      ie_q       <= 1'b0;
      divider_q  <= 16'd0;
      ss_q       <= '0;
      irq_q      <= 1'b0;
    end else begin
      ack_q    <= req;
      // Held off until strobe goes low
      served_q <= stb_i && (served_q || ack_q);
      start_q  <= wr && (adr_i == ctrl) && new_w[ctrl_go_bit] && !busy_i;
      if (wr) begin
        case (adr_i)
          ctrl: begin
            char_len_q <= new_w[ctrl_char_len_lsb +: 7];
            ie_q       <= new_w[ctrl_ie_bit];
          end
          divider: begin
            if (!busy_i) begin
              divider_q <= new_w[15:0];
            end
          end
          ss:      ss_q <= new_w[ss_count-1:0];
          default: ;
        endcase
      end
      // Done wins over a clearing control access
      if (done_i && ie_q) begin
        irq_q <= 1'b1;
      end else if (req && (adr_i == ctrl)) begin
        irq_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr && !busy_i && (adr_i == rx0_tx0)) begin
      tx_q[31:0] <= new_w;
    end
    if (wr && !busy_i && (adr_i == rx1_tx1)) begin
      tx_q[63:32] <= new_w;
    end
    if (done_i) begin
      rx_q <= rx_word_i;
    end
    if (req) begin
      rdat_q <= rd_w;
    end
  end

  assign ack_o      = ack_q;
  assign rdat_o     = rdat_q;
  assign start_o    = start_q;
  assign tx_word_o  = tx_q;
  assign char_len_o = char_len_q;
  assign divider_o  = divider_q;
  assign ss_n_o     = ~ss_q;
  assign irq_o      = irq_q;

  // Shifter must be idle whenever a transfer is kicked off
  a_no_start_busy: assert property (@(posedge clock) disable iff (reset)
    start_o |-> !busy_i);

endmodule

/* logic/spi_shifter.sv */
`timescale 1ns/1ns

module spi_shifter (
  input  logic        clock,
  input  logic        reset,
  input  logic        start_i,
  input  logic [63:0] tx_word_i,
  input  logic [6:0]  char_len_i,
  input  logic [15:0] divider_i,
  output logic        busy_o,
  output logic        done_o,
  output logic [63:0] rx_word_o,
  output logic        sck_o,
  output logic        mosi_o,
  input  logic        miso_i
);

  // Engine state
  logic        busy_q;
  logic        sck_q;
  logic [15:0] div_cnt_q;
  logic [6:0]  bits_left_q;
  // Data path
  logic [63:0] shift_q;
  logic [63:0] rx_q;
  // Helpers
  logic [6:0]  n_bits;
  logic        load;
  logic        tick;
  logic        last_fall;

  // Zero or out of range means a full 64 bits
  assign n_bits = ((char_len_i == 7'd0) || (char_len_i > 7'd64)) ? 7'd64 : char_len_i;
  assign load   = start_i && !busy_q;

  // End of an SCK half period
  assign tick = busy_q && (div_cnt_q == divider_i);

  // Final falling edge of the transfer
  assign last_fall = tick && sck_q && (bits_left_q == 7'd1);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q      <= 1'b0;
      sck_q       <= 1'b0;
      div_cnt_q   <= 16'd0;
      bits_left_q <= 7'd0;
    end else if (load) begin
      busy_q      <= 1'b1;
      sck_q       <= 1'b0;
      div_cnt_q   <= 16'd0;
      bits_left_q <= n_bits;
    end else if (busy_q) begin
      if (tick) begin
        div_cnt_q <= 16'd0;
        sck_q     <= ~sck_q;
        // Falling edge ends one bit
        if (sck_q) begin
          bits_left_q <= bits_left_q - 7'd1;
          if (bits_left_q == 7'd1) begin
            busy_q <= 1'b0;
          end
        end
      end else begin
        div_cnt_q <= div_cnt_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      // Left-align so bit N-1 leaves first
      shift_q <= tx_word_i << (7'd64 - n_bits);
      rx_q    <= '0;
    end else if (tick) begin
      if (!sck_q) begin
        // Rising edge, sample MISO
        rx_q <= {rx_q[62:0], miso_i};
      end else begin
        // Falling edge, next bit onto MOSI
        shift_q <= {shift_q[62:0], 1'b0};
      end
    end
  end

  assign busy_o    = busy_q;
  assign done_o    = last_fall;
  assign rx_word_o = rx_q;
  assign sck_o     = sck_q;
  // Idle low between transfers
  assign mosi_o    = busy_q && shift_q[63];

  // Done marks the last busy cycle only
  a_done_on_fall: assert property (@(posedge clock) disable iff (reset)
    done_o |-> busy_o ##1 !busy_o);

endmodule

/* logic/spi_apb_bridge.sv */
`timescale 1ns/1ns

module spi_apb_bridge (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [31:0]           paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [31:0]           pwdata_i,
  input  logic [3:0]            pstrb_i,
  output logic                  pready_o,
  output logic [31:0]           prdata_o,
  output logic                  pslverr_o,
  output spi_xip_pkg::reg_sel_t bus_adr_o,
  output logic [31:0]           bus_wdat_o,
  output logic [3:0]            bus_sel_o,
  output logic                  bus_we_o,
  output logic                  bus_stb_o,
  input  logic                  bus_ack_i,
  input  logic [31:0]           bus_rdat_i
);
  import spi_xip_pkg::*;

  // Sequencer control
  xip_state_t  state_q;
  xip_state_t  step_next;
  logic        stb_q;
  logic        fwd_q;
  logic        err_q;
  // Latched APB request and flash data
  logic [23:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  strb_q;
  logic        write_q;
  logic [31:0] rdata_q;
  // Decode
  logic        in_flash;
  logic        in_regs;
  logic        access;

  assign in_flash = (paddr_i >= flash_base) && (paddr_i <= flash_last);
  assign in_regs  = (paddr_i >= regs_base) && (paddr_i <= regs_last);
  // One access at a time, new ones only from idle
  assign access   = psel_i && penable_i && (state_q == idle);

  // Step order of the flash read
  always_comb begin
    case (state_q)
      send_cmd:      step_next = set_divider;
      set_divider:   step_next = set_ss;
      set_ss:        step_next = go_busy;
      go_busy:       step_next = wait_complete;
      // Poll again while go still reads set
      wait_complete: step_next = bus_rdat_i[ctrl_go_bit] ? wait_complete : read_data;
      read_data:     step_next = release_ss;
      release_ss:    step_next = respond;
      default:       step_next = idle;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= idle;
      stb_q   <= 1'b0;
      fwd_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        idle: begin
          if (access) begin
            if (in_regs) begin
              fwd_q   <= 1'b1;
              err_q   <= 1'b0;
              stb_q   <= 1'b1;
              state_q <= respond;
            end else if (in_flash && !pwrite_i) begin
              fwd_q   <= 1'b0;
              err_q   <= 1'b0;
              state_q <= send_cmd;
            end else begin
              // Flash write or unmapped
              fwd_q   <= 1'b0;
              err_q   <= 1'b1;
              state_q <= respond;
            end
          end
        end
        respond: begin
          // Forwarded access waits for its ack
          if (!fwd_q || bus_ack_i) begin
            stb_q   <= 1'b0;
            state_q <= idle;
          end
        end
        default: begin
          // Bus step, strobe low one cycle between steps
          if (bus_ack_i) begin
            stb_q   <= 1'b0;
            state_q <= step_next;
          end else begin
            stb_q <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      addr_q  <= paddr_i[23:0];
      wdata_q <= pwdata_i;
      strb_q  <= pstrb_i;
      write_q <= pwrite_i;
    end
    if ((state_q == read_data) && bus_ack_i) begin
      rdata_q <= bus_rdat_i;
    end
  end

  // Bus request, fixed per sequencer state
  always_comb begin
    bus_adr_o  = reg_sel_t'(addr_q[4:0]);
    bus_wdat_o = wdata_q;
    bus_sel_o  = strb_q;
    bus_we_o   = write_q;
    case (state_q)
      send_cmd: begin
        bus_adr_o  = rx1_tx1;
        bus_wdat_o = {flash_read_op, addr_q};
        bus_sel_o  = 4'hf;
        bus_we_o   = 1'b1;
      end
      set_divider: begin
        bus_adr_o  = divider;
        bus_wdat_o = {16'b0, xip_divider};
        bus_sel_o  = 4'hf;
        bus_we_o   = 1'b1;
      end
      set_ss, release_ss: begin
        bus_adr_o  = ss;
        bus_wdat_o = (state_q == set_ss) ? 32'd1 : 32'd0;
        bus_sel_o  = 4'hf;
        bus_we_o   = 1'b1;
      end
      go_busy, wait_complete: begin
        bus_adr_o  = ctrl;
        // Length field zero selects 64 bits
        bus_wdat_o = 32'd1 << ctrl_go_bit;
        bus_sel_o  = 4'hf;
        bus_we_o   = (state_q == go_busy);
      end
      read_data: begin
        bus_adr_o = rx0_tx0;
        bus_sel_o = 4'hf;
        bus_we_o  = 1'b0;
      end
      default: ;
    endcase
  end

  assign bus_stb_o = stb_q;
  assign pready_o  = (state_q == respond) && (!fwd_q || bus_ack_i);
  assign pslverr_o = (state_q == respond) && err_q;
  assign prdata_o  = fwd_q ? bus_rdat_i : rdata_q;

  // Strobe holds until the register block answers
  a_stb_until_ack: assert property (@(posedge clock) disable iff (reset)
    bus_stb_o && !bus_ack_i |=> bus_stb_o);

endmodule

/* logic/spi_xip_top.sv */
`timescale 1ns/1ns

module spi_xip_top (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [31:0]                      paddr_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [31:0]                      pwdata_i,
  input  logic [3:0]                       pstrb_i,
  output logic                             pready_o,
  output logic [31:0]                      prdata_o,
  output logic                             pslverr_o,
  output logic                             sck_o,
  output logic [spi_xip_pkg::ss_count-1:0] ss_n_o,
  output logic                             mosi_o,
  input  logic                             miso_i,
  output logic                             irq_o
);
  import spi_xip_pkg::*;

  // Internal register bus
  reg_sel_t    bus_adr;
  logic [31:0] bus_wdat;
  logic [3:0]  bus_sel;
  logic        bus_we;
  logic        bus_stb;
  logic        bus_ack;
  logic [31:0] bus_rdat;
  // Register block to shifter
  logic        start;
  logic [63:0] tx_word;
  logic [6:0]  char_len;
  logic [15:0] div_val;
  logic        busy;
  logic        done;
  logic [63:0] rx_word;

  spi_apb_bridge i_bridge (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .pstrb_i    (pstrb_i),
    .pready_o   (pready_o),
    .prdata_o   (prdata_o),
    .pslverr_o  (pslverr_o),
    .bus_adr_o  (bus_adr),
    .bus_wdat_o (bus_wdat),
    .bus_sel_o  (bus_sel),
    .bus_we_o   (bus_we),
    .bus_stb_o  (bus_stb),
    .bus_ack_i  (bus_ack),
    .bus_rdat_i (bus_rdat)
  );

  spi_regs i_regs (
    .clock      (clock),
    .reset      (reset),
    .adr_i      (bus_adr),
    .wdat_i     (bus_wdat),
    .sel_i      (bus_sel),
    .we_i       (bus_we),
    .stb_i      (bus_stb),
    .ack_o      (bus_ack),
    .rdat_o     (bus_rdat),
    .start_o    (start),
    .tx_word_o  (tx_word),
    .char_len_o (char_len),
    .divider_o  (div_val),
    .busy_i     (busy),
    .done_i     (done),
    .rx_word_i  (rx_word),
    .ss_n_o     (ss_n_o),
    .irq_o      (irq_o)
  );

  spi_shifter i_shifter (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start),
    .tx_word_i  (tx_word),
    .char_len_i (char_len),
    .divider_i  (div_val),
    .busy_o     (busy),
    .done_o     (done),
    .rx_word_o  (rx_word),
    .sck_o      (sck_o),
    .mosi_o     (mosi_o),
    .miso_i     (miso_i)
  );

endmodule

/* verification/flash_model.sv */
`timescale 1ns/1ns

module flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  // Bits seen since select went low
  logic [6:0]  bit_cnt = '0;
  logic [31:0] shift_in = '0;
  // Command byte and 24-bit address, latched after 32 bits
  logic [31:0] cmd_q = '0;
  logic        dbit = 1'b0;
  // Read phase decode
  logic        reading;
  logic [5:0]  idx;
  logic [7:0]  data_byte;

  assign reading = (bit_cnt >= 7'd32) && (cmd_q[31:24] == 8'h03);

  // Bit position inside the data phase
  assign idx = 6'(bit_cnt - 7'd32);

  // Byte for address A+k, k taken from the bit position
  assign data_byte = (cmd_q[7:0] + {6'b0, idx[4:3]}) ^ 8'h5a;

  // Mode 0, MOSI taken on the rising edge
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt  <= '0;
      shift_in <= '0;
      cmd_q    <= '0;
    end else begin
      shift_in <= {shift_in[30:0], mosi_i};
      bit_cnt  <= bit_cnt + 7'd1;
      if (bit_cnt == 7'd31) begin
        cmd_q <= {shift_in[30:0], mosi_i};
      end
    end
  end

  // Next data bit on the falling edge, MSB first
  always @(negedge sck_i) begin
    dbit <= data_byte[3'd7 - idx[2:0]];
  end

  // Without a read command the model echoes MOSI
  assign miso_o = ss_n_i ? 1'b0 : (reading ? dbit : mosi_i);

endmodule

/* verification/spi_xip_tb.sv */
`timescale 1ns/1ns

module spi_xip_tb;
  import spi_xip_pkg::*;

  // DUT pins
  logic        clock;
  logic        reset;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;
  logic        sck;
  logic [7:0]  ss_n;
  logic        mosi;
  logic        miso;
  logic        irq;
  // Expected values and check enables
  logic        rst_chk;
  logic        chk_rdata;
  logic [31:0] exp_rdata;
  logic        exp_err;
  logic        xip_mode;
  logic        reg_mode;
  logic        err_mode;
  logic        sw_mode;
  logic        chk_irq;
  logic        exp_irq;
  int          exp_period;
  // SCK monitor, updated on the falling clock edge
  int          cyc;
  int          last_rise;
  int          period;
  int          rises;
  logic        sck_rise;
  logic        sck_d;
  // Stimulus scratch
  logic [31:0] seed;
  logic [31:0] rd;
  logic [31:0] wd;
  logic [31:0] tx0;
  logic [3:0]  strb;
  logic [15:0] div_val;
  int          waited;

  spi_xip_top i_spi_xip_top (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .pready_o  (pready),
    .prdata_o  (prdata),
    .pslverr_o (pslverr),
    .sck_o     (sck),
    .ss_n_o    (ss_n),
    .mosi_o    (mosi),
    .miso_i    (miso),
    .irq_o     (irq)
  );

  flash_model i_flash (
    .sck_i  (sck),
    .ss_n_i (ss_n[0]),
    .mosi_i (mosi),
    .miso_o (miso)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // All bits of each byte lane that has its strobe set
  function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
    return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
  endfunction

  // Four flash bytes from A, first byte lands in the MSB
  function automatic logic [31:0] flash_word(input logic [23:0] a);
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < 4; k++) begin
      w = {w[23:0], (a[7:0] + 8'(k)) ^ 8'h5a};
    end
    return w;
  endfunction

  // One APB access, setup then access phase
  task automatic apb(input logic [31:0] addr, input logic wr, input logic [31:0] wdat,
                     input logic [3:0] lanes, output logic [31:0] rdat);
    int n;
    @(negedge clock);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdat;
    pstrb   = lanes;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clock);
    penable = 1'b1;
    n = 0;
    @(negedge clock);
    while (!pready) begin
      if (n > 4000) begin
        $display("TB FAILED");
        $fatal(1, "APB access to %h never got pready_o", addr);
      end
      @(negedge clock);
      n++;
    end
    rdat = prdata;
    // Drop the bus after the completing edge
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  always @(negedge clock) begin
    cyc = cyc + 1;
    sck_rise = sck && !sck_d;
    if (sck_rise) begin
      period    = cyc - last_rise;
      last_rise = cyc;
      rises     = sw_mode ? rises + 1 : 0;
    end
    sck_d = sck;
  end

  a_reset: assert property (@(posedge clock) disable iff (reset)
    rst_chk |-> ({pready, pslverr, sck, mosi, irq} == 5'b0)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: pready_o,pslverr_o,sck_o,mosi_o,irq_o got %b expected 00000",
           $time, $sampled({pready, pslverr, sck, mosi, irq}));
  end

  a_reset_ss: assert property (@(posedge clock) disable iff (reset)
    rst_chk |-> (ss_n == 8'hff)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: ss_n_o got %h expected ff", $time, $sampled(ss_n));
  end

  a_rdata: assert property (@(posedge clock) disable iff (reset)
    (pready && chk_rdata) |-> (prdata == exp_rdata)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: prdata_o got %h expected %h", $time, $sampled(prdata),
           exp_rdata);
  end

  a_err: assert property (@(posedge clock) disable iff (reset)
    pready |-> (pslverr == exp_err)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: pslverr_o got %b expected %b", $time, $sampled(pslverr),
           exp_err);
  end

  // Select released before the XIP read answers
  a_xip_ss: assert property (@(posedge clock) disable iff (reset)
    (pready && xip_mode) |-> (ss_n == 8'hff)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: ss_n_o got %h expected ff", $time, $sampled(ss_n));
  end

  a_latency: assert property (@(posedge clock) disable iff (reset)
    (reg_mode && $rose(penable)) |-> !pready ##1 !pready ##1 pready) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: pready_o got %b expected 1 two cycles after penable_i",
           $time, $sampled(pready));
  end

  a_no_sck: assert property (@(posedge clock) disable iff (reset)
    err_mode |-> !sck) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: sck_o got %b expected 0", $time, $sampled(sck));
  end

  a_period: assert property (@(posedge clock) disable iff (reset)
    (sw_mode && sck_rise && rises >= 2) |-> (period == exp_period)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: sck_o period got %0d expected %0d", $time, period, exp_period);
  end

  // Interrupt only once all 16 bits are clocked
  a_irq_end: assert property (@(posedge clock) disable iff (reset)
    (sw_mode && $rose(irq)) |-> (rises == 16)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: irq_o rose after %0d sck_o edges expected 16", $time, rises);
  end

  a_irq: assert property (@(posedge clock) disable iff (reset)
    chk_irq |-> (irq == exp_irq)) else begin
    $display("TB FAILED");
    $fatal(1, "Fail at %0t: irq_o got %b expected %b", $time, $sampled(irq), exp_irq);
  end

  initial begin
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    pstrb = '0;
    {rst_chk, chk_rdata, xip_mode, reg_mode, err_mode, sw_mode} = '0;
    {chk_irq, exp_irq, exp_err} = '0;
    exp_rdata = '0;
    exp_period = 0;
    cyc = 0;
    last_rise = 0;
    period = 0;
    rises = 0;
    sck_rise = 1'b0;
    sck_d = 1'b0;
    seed = 32'hb934;
    reset = 1'b1;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    rst_chk = 1'b1;
    @(negedge clock);
    rst_chk = 1'b0;

    // Divider write with random lanes, then read back
    reg_mode = 1'b1;
    seed = xorshift32(seed);
    wd = seed;
    seed = xorshift32(seed);
    strb = seed[3:0];
    apb(regs_base + 32'(divider), 1'b1, wd, strb, rd);
    // Unstrobed lanes keep the zero reset value
    exp_rdata = wd & lane_mask(strb) & 32'h0000_ffff;
    chk_rdata = 1'b1;
    apb(regs_base + 32'(divider), 1'b0, 32'h0, 4'hf, rd);
    chk_rdata = 1'b0;
    reg_mode = 1'b0;

    // XIP reads at random flash addresses
    xip_mode = 1'b1;
    repeat (4) begin
      seed = xorshift32(seed);
      exp_rdata = flash_word(seed[23:0]);
      chk_rdata = 1'b1;
      apb(flash_base + {4'b0, seed[27:0]}, 1'b0, 32'h0, 4'hf, rd);
      chk_rdata = 1'b0;
    end
    xip_mode = 1'b0;

    // Flash write and unmapped read both fail
    err_mode = 1'b1;
    exp_err = 1'b1;
    seed = xorshift32(seed);
    apb(flash_base + {4'b0, seed[27:0]}, 1'b1, seed, 4'hf, rd);
    seed = xorshift32(seed);
    apb(32'h2000_0000 + {4'b0, seed[27:0]}, 1'b0, 32'h0, 4'hf, rd);
    exp_err = 1'b0;
    err_mode = 1'b0;

    // Software transfer, 16 bits with interrupt
    seed = xorshift32(seed);
    tx0 = seed;
    seed = xorshift32(seed);
    div_val = {14'b0, seed[1:0]} + 16'd1;
    exp_period = 2 * (int'(div_val) + 1);
    apb(regs_base + 32'(rx0_tx0), 1'b1, tx0, 4'hf, rd);
    apb(regs_base + 32'(rx1_tx1), 1'b1, seed, 4'hf, rd);
    apb(regs_base + 32'(divider), 1'b1, {16'b0, div_val}, 4'hf, rd);
    apb(regs_base + 32'(ss), 1'b1, 32'h1, 4'hf, rd);
    sw_mode = 1'b1;
    apb(regs_base + 32'(ctrl), 1'b1, 32'h0000_1110, 4'hf, rd);
    waited = 0;
    while (!irq) begin
      if (waited > 4000) begin
        $display("TB FAILED");
        $fatal(1, "Software transfer never raised the interrupt");
      end
      @(negedge clock);
      waited++;
    end
    chk_irq = 1'b1;
    exp_irq = 1'b1;
    @(negedge clock);
    chk_irq = 1'b0;
    // Go must read clear, length and enable kept
    exp_rdata = 32'h0000_1010;
    chk_rdata = 1'b1;
    apb(regs_base + 32'(ctrl), 1'b0, 32'h0, 4'hf, rd);
    exp_irq = 1'b0;
    chk_irq = 1'b1;
    // Echoed bits, right-aligned
    exp_rdata = {16'b0, tx0[15:0]};
    apb(regs_base + 32'(rx0_tx0), 1'b0, 32'h0, 4'hf, rd);
    chk_rdata = 1'b0;
    chk_irq = 1'b0;
    apb(regs_base + 32'(ss), 1'b1, 32'h0, 4'hf, rd);
    sw_mode = 1'b0;

    $display("TB PASSED");
    $finish;
  end

endmodule

/* build.f */
logic/spi_xip_pkg.sv
logic/spi_regs.sv
logic/spi_shifter.sv
logic/spi_apb_bridge.sv
logic/spi_xip_top.sv
verification/flash_model.sv
verification/spi_xip_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the simulation; exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module spi_xip_tb \
  -f build.f \
  -o spi_xip_sim \
  && ./obj_dir/spi_xip_sim \
  || exit 1
